// File: gsau_defines.svh
`ifndef GSAU_DEFINES_SVH
`define GSAU_DEFINES_SVH

// array dimension, also the number of vector lanes
`define GSAU_LANES 4

// signed operand width per lane
`define GSAU_OP_W 8

// signed result width per lane, wraps on overflow
`define GSAU_PSUM_W 16

// destination tag width
`define GSAU_TAG_W 8

// cycles from accept edge to out_en, 2*(lanes-1) for skew plus deskew
`define GSAU_SA_LATENCY 6

// tag and result fifo depth, doubles as the credit limit
`define GSAU_QDEPTH 4

`endif

// File: gsau_pkg.sv
`default_nettype none

`include "gsau_defines.svh"

package gsau_pkg;

  // operand vector, lane i in bits [i*op_w +: op_w]
  typedef logic [`GSAU_LANES*`GSAU_OP_W-1:0] vreg_t;

  // result vector, lane j in bits [j*psum_w +: psum_w]
  typedef logic [`GSAU_LANES*`GSAU_PSUM_W-1:0] psum_t;

  // destination register tag from the scoreboard
  typedef logic [`GSAU_TAG_W-1:0] vdst_t;

  // outstanding results, counts 0 up to qdepth inclusive
  typedef logic [$clog2(`GSAU_QDEPTH+1)-1:0] credit_t;

  // issue control
  // issue: normal operation, weights may load when the array is idle
  // wait_drain: a weight is waiting on in-flight inputs
  typedef enum logic {
    ISSUE      = 1'b0,
    WAIT_DRAIN = 1'b1
  } gsau_state_t;

endpackage

`default_nettype wire

// File: sa_if.sv
`default_nettype none

interface sa_if
  import gsau_pkg::*;
;

  // operand vector, weight row or input depending on strobe
  vreg_t array_in;
  // single-cycle strobes, never both high
  logic  weight_en;
  logic  input_en;

  // result strobe and vector, aligned across lanes
  logic  out_en;
  psum_t array_out;
  // some input still travelling through the pipeline
  logic  busy;

  modport control (
    output array_in,
    output weight_en,
    output input_en,
    input  out_en,
    input  array_out,
    input  busy
  );

  modport array (
    input  array_in,
    input  weight_en,
    input  input_en,
    output out_en,
    output array_out,
    output busy
  );

endinterface

`default_nettype wire

// File: sync_fifo.sv
`default_nettype none

module sync_fifo #(
  parameter int DEPTH = 4,
  parameter int WIDTH = 8
) (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             i_wr,
  input  logic             i_rd,
  input  logic [WIDTH-1:0] i_din,
  output logic [WIDTH-1:0] o_dout,
  output logic             o_empty,
  output logic             o_full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_wr;
  logic             do_rd;

  assign o_empty = (count == '0);
  assign o_full  = (count == CNT_W'(DEPTH));

  // pop only real data, a full fifo still takes a write when it pops
  assign do_rd = i_rd && !o_empty;
  assign do_wr = i_wr && (!o_full || do_rd);

  // head word straight from storage, no read latency
  assign o_dout = mem[rd_ptr];

  always_ff @(posedge CLK) begin
    if (do_wr) begin
      mem[wr_ptr] <= i_din;
    end
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // pointers wrap at depth, depth need not be a power of two
      if (do_wr) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_wr && !do_rd) begin
        count <= count + 1'b1;
      end else if (do_rd && !do_wr) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: systolic_array.sv
`default_nettype none

`include "gsau_defines.svh"

module systolic_array
  import gsau_pkg::*;
(
  input  logic CLK,
  input  logic nRST,
  sa_if.array  sa
);

  localparam int N   = `GSAU_LANES;
  localparam int OW  = `GSAU_OP_W;
  localparam int PW  = `GSAU_PSUM_W;
  localparam int LAT = `GSAU_SA_LATENCY;

  // weight rows, row 0 is the most recent load
  vreg_t                w_rows   [N];
  // skew stage k holds the operand vector delayed k+1 cycles
  vreg_t                skew_q   [N-1];
  // operand entering column 0 of each row
  logic signed [OW-1:0] x_in     [N];
  // per-cell weight and operand, operand copy moving right
  logic signed [OW-1:0] w_op     [N][N];
  logic signed [OW-1:0] x_op     [N][N];
  logic signed [OW-1:0] x_q      [N][N-1];
  // partial sums moving down the columns
  logic signed [PW-1:0] p_next   [N][N];
  logic signed [PW-1:0] p_q      [N][N];
  // bottom row output, lanes still skewed
  psum_t                row_out;
  // deskew stage k holds the bottom row delayed k+1 cycles
  psum_t                deskew_q [N-1];
  // one bit per input in flight
  logic [LAT-1:0]       vld_q;
  logic                 out_q;

  // new row enters at the top, older rows move down, last row falls off
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      for (int r = 0; r < N; r++) begin
        w_rows[r] <= '0;
      end
    end else if (sa.weight_en) begin
      w_rows[0] <= sa.array_in;
      for (int r = 1; r < N; r++) begin
        w_rows[r] <= w_rows[r-1];
      end
    end
  end

  // element i reaches row i after i cycles
  // element 0 goes straight in on the accept edge
  always_comb begin
    x_in[0] = sa.array_in[0 +: OW];
    for (int i = 1; i < N; i++) begin
      x_in[i] = skew_q[i-1][i*OW +: OW];
    end
  end

  // cell (i,j) fires i+j cycles after accept
  always_comb begin
    for (int i = 0; i < N; i++) begin
      for (int j = 0; j < N; j++) begin
        w_op[i][j] = w_rows[i][j*OW +: OW];
        if (j == 0) begin
          x_op[i][j] = x_in[i];
        end else begin
          x_op[i][j] = x_q[i][j-1];
        end
        // signed 8x8 product in 16 bits, sum wraps
        if (i == 0) begin
          p_next[i][j] = w_op[i][j] * x_op[i][j];
        end else begin
          p_next[i][j] = p_q[i-1][j] + w_op[i][j] * x_op[i][j];
        end
      end
    end
  end

  always_comb begin
    for (int j = 0; j < N; j++) begin
      row_out[j*PW +: PW] = p_q[N-1][j];
    end
  end

  // lane j leaves the bottom row at cycle N-1+j, hold it N-1-j more cycles
  always_comb begin
    for (int j = 0; j < N-1; j++) begin
      sa.array_out[j*PW +: PW] = deskew_q[N-2-j][j*PW +: PW];
    end
    sa.array_out[(N-1)*PW +: PW] = p_q[N-1][N-1];
  end

  // datapath registers, garbage flows freely and only valid bits matter
  always_ff @(posedge CLK) begin
    skew_q[0] <= sa.array_in;
    for (int k = 1; k < N-1; k++) begin
      skew_q[k] <= skew_q[k-1];
    end
    for (int i = 0; i < N; i++) begin
      for (int j = 0; j < N; j++) begin
        p_q[i][j] <= p_next[i][j];
        if (j < N-1) begin
          x_q[i][j] <= x_op[i][j];
        end
      end
    end
    deskew_q[0] <= row_out;
    for (int k = 1; k < N-1; k++) begin
      deskew_q[k] <= deskew_q[k-1];
    end
  end

  // valid pipeline tracks inputs through the array
  // extra flop aligns out_en with the deskewed result
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      vld_q <= '0;
      out_q <= 1'b0;
    end else begin
      vld_q <= {vld_q[LAT-2:0], sa.input_en};
      out_q <= vld_q[LAT-1];
    end
  end

  assign sa.out_en = out_q;
  // any input still reading weights
  assign sa.busy   = |vld_q;

endmodule

`default_nettype wire

// File: gsau_control_unit.sv
`default_nettype none

`include "gsau_defines.svh"

module gsau_control_unit
  import gsau_pkg::*;
(
  input  logic  CLK,
  input  logic  nRST,
  sa_if.control sa,
  input  logic  i_sb_valid,
  input  logic  i_sb_weight,
  input  vdst_t i_sb_vdst,
  input  logic  i_veg_valid,
  input  vreg_t i_veg_vdata,
  output logic  o_ready,
  output logic  o_iss_valid,
  output vdst_t o_iss_vdst,
  output logic  o_tag_wr,
  output vdst_t o_tag_din,
  input  logic  i_wb_done
);

  gsau_state_t state_q;
  gsau_state_t state_d;
  credit_t     credit_q;
  logic        credit_ok;
  logic        accept;
  logic        in_acc;
  logic        wt_acc;

  // room left in the result fifo for one more input
  assign credit_ok = (credit_q < credit_t'(`GSAU_QDEPTH));

  // weights wait for an empty pipeline, inputs wait for a credit
  // selected by the presented instruction, valids not involved
  always_comb begin
    if (state_q != ISSUE) begin
      o_ready = 1'b0;
    end else if (i_sb_weight) begin
      o_ready = !sa.busy;
    end else begin
      o_ready = credit_ok;
    end
  end

  // both sources must offer, one instruction per edge
  assign accept = i_sb_valid && i_veg_valid && o_ready;
  assign in_acc = accept && !i_sb_weight;
  assign wt_acc = accept && i_sb_weight;

  // strobes to the array on the accept edge itself
  assign sa.array_in  = i_veg_vdata;
  assign sa.weight_en = wt_acc;
  assign sa.input_en  = in_acc;

  // only inputs produce results and need a tag
  assign o_tag_wr  = in_acc;
  assign o_tag_din = i_sb_vdst;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ISSUE: begin
        // weight arrives behind in-flight inputs
        if (i_sb_valid && i_sb_weight && sa.busy) begin
          state_d = WAIT_DRAIN;
        end
      end
      WAIT_DRAIN: begin
        if (!sa.busy) begin
          state_d = ISSUE;
        end
      end
      default: begin
        state_d = ISSUE;
      end
    endcase
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      state_q     <= ISSUE;
      credit_q    <= '0;
      o_iss_valid <= 1'b0;
    end else begin
      state_q <= state_d;
      // up on input accept, down on writeback, both cancel out
      case ({in_acc, i_wb_done})
        2'b10:   credit_q <= credit_q + 1'b1;
        2'b01:   credit_q <= credit_q - 1'b1;
        default: credit_q <= credit_q;
      endcase
      // issue notice one cycle after every accept
      o_iss_valid <= accept;
    end
  end

  always_ff @(posedge CLK) begin
    if (accept) begin
      o_iss_vdst <= i_sb_vdst;
    end
  end

endmodule

`default_nettype wire

// File: gsau_top.sv
`default_nettype none

`include "gsau_defines.svh"

module gsau_top
  import gsau_pkg::*;
(
  input  logic  CLK,
  input  logic  nRST,
  // scoreboard side
  input  logic  i_sb_valid,
  input  logic  i_sb_weight,
  input  vdst_t i_sb_vdst,
  output logic  o_sb_ready,
  output logic  o_iss_valid,
  output vdst_t o_iss_vdst,
  // register file side
  input  logic  i_veg_valid,
  input  vreg_t i_veg_vdata,
  output logic  o_veg_ready,
  // writeback side
  output logic  o_wb_valid,
  output psum_t o_wb_psum,
  output vdst_t o_wb_vdst,
  input  logic  i_wb_ready
);

  localparam int RES_W = $bits(vdst_t) + $bits(psum_t);

  sa_if sa ();

  logic             ready;
  logic             tag_wr;
  vdst_t            tag_din;
  vdst_t            tag_head;
  logic             res_empty;
  logic [RES_W-1:0] res_head;
  logic             wb_done;

  gsau_control_unit u_ctrl (
    .CLK         (CLK),
    .nRST        (nRST),
    .sa          (sa.control),
    .i_sb_valid  (i_sb_valid),
    .i_sb_weight (i_sb_weight),
    .i_sb_vdst   (i_sb_vdst),
    .i_veg_valid (i_veg_valid),
    .i_veg_vdata (i_veg_vdata),
    .o_ready     (ready),
    .o_iss_valid (o_iss_valid),
    .o_iss_vdst  (o_iss_vdst),
    .o_tag_wr    (tag_wr),
    .o_tag_din   (tag_din),
    .i_wb_done   (wb_done)
  );

  systolic_array u_array (
    .CLK  (CLK),
    .nRST (nRST),
    .sa   (sa.array)
  );

  // tags in issue order, popped when the matching result leaves the array
  // credits keep both fifos from overflowing, so full and empty go unused
  sync_fifo #(
    .DEPTH (`GSAU_QDEPTH),
    .WIDTH ($bits(vdst_t))
  ) tag_fifo (
    .CLK     (CLK),
    .nRST    (nRST),
    .i_wr    (tag_wr),
    .i_rd    (sa.out_en),
    .i_din   (tag_din),
    .o_dout  (tag_head),
    .o_empty (),
    .o_full  ()
  );

  // result paired with its tag, tag in the upper bits
  sync_fifo #(
    .DEPTH (`GSAU_QDEPTH),
    .WIDTH (RES_W)
  ) result_fifo (
    .CLK     (CLK),
    .nRST    (nRST),
    .i_wr    (sa.out_en),
    .i_rd    (wb_done),
    .i_din   ({tag_head, sa.array_out}),
    .o_dout  (res_head),
    .o_empty (res_empty),
    .o_full  ()
  );

  assign o_sb_ready  = ready;
  assign o_veg_ready = ready;

  assign o_wb_valid             = !res_empty;
  assign {o_wb_vdst, o_wb_psum} = res_head;
  assign wb_done                = o_wb_valid && i_wb_ready;

endmodule

`default_nettype wire

// File: tb_gsau.sv
`default_nettype none

`include "gsau_defines.svh"

module tb_gsau
  import gsau_pkg::*;
;

  localparam int N_ROWS  = 24;
  localparam int DRV_DLY = 10;
  localparam int OW      = `GSAU_OP_W;
  localparam int PW      = `GSAU_PSUM_W;
  // writebacks are blocked from this row on to hit the credit limit
  localparam int CREDIT_ROW = 16;
  localparam int HOLD       = 4;
  localparam int TIMEOUT    = N_ROWS * (`GSAU_SA_LATENCY + 20);

  logic  CLK;
  logic  nRST;
  logic  i_sb_valid;
  logic  i_sb_weight;
  vdst_t i_sb_vdst;
  logic  o_sb_ready;
  logic  o_iss_valid;
  vdst_t o_iss_vdst;
  logic  i_veg_valid;
  vreg_t i_veg_vdata;
  logic  o_veg_ready;
  logic  o_wb_valid;
  psum_t o_wb_psum;
  vdst_t o_wb_vdst;
  logic  i_wb_ready;

  // stimulus table
  logic  row_wt  [N_ROWS];
  vdst_t row_tag [N_ROWS];
  vreg_t row_vec [N_ROWS];

  // reference weights, row 0 newest, and results still owed by the dut
  vreg_t model_w [`GSAU_LANES];
  psum_t exp_psum [$];
  vdst_t exp_tag  [$];

  logic [31:0] lfsr;
  logic        wb_block;
  logic        acc_prev;
  vdst_t       tag_prev;
  int          cycles;

  gsau_top dut (
    .CLK         (CLK),
    .nRST        (nRST),
    .i_sb_valid  (i_sb_valid),
    .i_sb_weight (i_sb_weight),
    .i_sb_vdst   (i_sb_vdst),
    .o_sb_ready  (o_sb_ready),
    .o_iss_valid (o_iss_valid),
    .o_iss_vdst  (o_iss_vdst),
    .i_veg_valid (i_veg_valid),
    .i_veg_vdata (i_veg_vdata),
    .o_veg_ready (o_veg_ready),
    .o_wb_valid  (o_wb_valid),
    .o_wb_psum   (o_wb_psum),
    .o_wb_vdst   (o_wb_vdst),
    .i_wb_ready  (i_wb_ready)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  task automatic abort_run;
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string msg);
    $display("MISMATCH at time %0t: %s", $time, msg);
    abort_run();
  endtask

  task automatic report_error(input string msg);
    $display("ERROR at time %0t: %s", $time, msg);
    abort_run();
  endtask

  // galois form, taps x^32+x^22+x^2+x+1, output bit is s[0]
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic set_row(input int idx, input logic wt, input vreg_t vec);
    row_wt[idx]  = wt;
    row_tag[idx] = vdst_t'(8'ha0 + idx * 5);
    row_vec[idx] = vec;
  endtask

  task automatic load_table;
    // identity, e3 first so that row i ends up as e_i
    set_row(0, 1'b1, 32'h0100_0000);
    set_row(1, 1'b1, 32'h0001_0000);
    set_row(2, 1'b1, 32'h0000_0100);
    set_row(3, 1'b1, 32'h0000_0001);
    set_row(4, 1'b0, 32'h7f80_01ff);
    set_row(5, 1'b0, 32'h1234_56f0);
    set_row(6, 1'b0, 32'h8080_8080);
    // extreme and mixed weights
    set_row(7, 1'b1, 32'h8080_8080);
    set_row(8, 1'b1, 32'h7f01_7f80);
    set_row(9, 1'b1, 32'hff02_fe03);
    set_row(10, 1'b1, 32'h1122_3344);
    set_row(11, 1'b0, 32'h8080_8080);
    set_row(12, 1'b0, 32'h7f7f_7f7f);
    set_row(13, 1'b0, 32'hdead_beef);
    // weight change right behind inputs in flight
    set_row(14, 1'b1, 32'h05fb_0af6);
    set_row(15, 1'b0, 32'h0102_0304);
    // credit phase, all inputs
    set_row(16, 1'b0, 32'hc0ff_ee00);
    set_row(17, 1'b0, 32'h0bad_f00d);
    set_row(18, 1'b0, 32'h7f80_ff01);
    set_row(19, 1'b0, 32'h1357_9bdf);
    set_row(20, 1'b0, 32'h2468_ace0);
    set_row(21, 1'b1, 32'h8001_7fff);
    set_row(22, 1'b0, 32'hffff_ffff);
    set_row(23, 1'b0, 32'h8080_8080);
  endtask

  // lane j = sum over rows i of w[i][j] * x[i], kept to 16 bits
  task automatic apply_model(input int idx);
    psum_t p;
    int    sum;
    if (row_wt[idx]) begin
      for (int r = `GSAU_LANES - 1; r > 0; r--) begin
        model_w[r] = model_w[r-1];
      end
      model_w[0] = row_vec[idx];
    end else begin
      for (int j = 0; j < `GSAU_LANES; j++) begin
        sum = 0;
        for (int i = 0; i < `GSAU_LANES; i++) begin
          sum += int'($signed(model_w[i][j*OW +: OW])) *
                 int'($signed(row_vec[idx][i*OW +: OW]));
        end
        p[j*PW +: PW] = sum[PW-1:0];
      end
      exp_psum.push_back(p);
      exp_tag.push_back(row_tag[idx]);
    end
  endtask

  task automatic present_row(input int idx);
    i_sb_valid  = 1'b1;
    i_veg_valid = 1'b1;
    i_sb_weight = row_wt[idx];
    i_sb_vdst   = row_tag[idx];
    i_veg_vdata = row_vec[idx];
    apply_model(idx);
  endtask

  task automatic idle_inputs;
    i_sb_valid  = 1'b0;
    i_veg_valid = 1'b0;
  endtask

  // ready seen at a falling edge means acceptance on the next rising edge
  task automatic wait_accept(input logic must_be_ready);
    @(negedge CLK);
    if (must_be_ready) begin
      assert (o_sb_ready)
      else report_error("ready went low before the credit limit was reached");
    end
    while (!o_sb_ready) begin
      @(negedge CLK);
    end
    @(posedge CLK);
    #DRV_DLY;
  endtask

  // queue is popped at falling edges, so look at it on rising ones
  task automatic drain_results;
    @(posedge CLK);
    while (exp_psum.size() != 0) begin
      @(posedge CLK);
    end
  endtask

  // writeback back-pressure, one lfsr bit per cycle
  always @(posedge CLK) begin
    #DRV_DLY;
    if (wb_block) begin
      i_wb_ready = 1'b0;
    end else begin
      i_wb_ready = lfsr[0];
      lfsr = lfsr_step(lfsr);
    end
  end

  always @(posedge CLK) begin
    cycles++;
    if (cycles > TIMEOUT) begin
      report_error($sformatf("run did not finish within %0d cycles", TIMEOUT));
    end
  end

  // monitor samples at the falling edge, away from both clock and drive
  always @(negedge CLK) begin
    if (nRST) begin
      assert (o_sb_ready == o_veg_ready)
      else report_mismatch("o_sb_ready and o_veg_ready differ");
      // issue notice belongs to the accept one cycle earlier
      if (acc_prev) begin
        assert (o_iss_valid && o_iss_vdst == tag_prev)
        else report_mismatch($sformatf("issue notice valid %0b tag %h, expected tag %h",
                                       o_iss_valid, o_iss_vdst, tag_prev));
      end else begin
        assert (!o_iss_valid)
        else report_mismatch("issue notice without an accepted instruction");
      end
      acc_prev = i_sb_valid && i_veg_valid && o_sb_ready;
      tag_prev = i_sb_vdst;
      if (o_wb_valid && i_wb_ready) begin
        assert (exp_psum.size() > 0)
        else report_error("writeback arrived with no result outstanding");
        assert (o_wb_psum == exp_psum[0] && o_wb_vdst == exp_tag[0])
        else report_mismatch($sformatf("wb tag %h psum %h, expected tag %h psum %h",
                                       o_wb_vdst, o_wb_psum, exp_tag[0], exp_psum[0]));
        void'(exp_psum.pop_front());
        void'(exp_tag.pop_front());
      end
    end
  end

  initial begin
    nRST        = 1'b0;
    i_sb_valid  = 1'b0;
    i_sb_weight = 1'b0;
    i_sb_vdst   = '0;
    i_veg_valid = 1'b0;
    i_veg_vdata = '0;
    i_wb_ready  = 1'b0;
    wb_block    = 1'b0;
    lfsr        = 32'hc628ff68;
    acc_prev    = 1'b0;
    tag_prev    = '0;
    cycles      = 0;
    for (int r = 0; r < `GSAU_LANES; r++) begin
      model_w[r] = '0;
    end
    load_table();
    repeat (4) @(posedge CLK);
    #DRV_DLY;
    nRST = 1'b1;
    @(negedge CLK);
    assert (o_sb_ready && o_veg_ready && !o_wb_valid && !o_iss_valid)
    else report_error("outputs not in their idle state after reset");
    @(posedge CLK);
    #DRV_DLY;
    for (int idx = 0; idx < N_ROWS; idx++) begin
      if (idx == CREDIT_ROW) begin
        // start from zero credits, then stop all writebacks
        idle_inputs();
        drain_results();
        wb_block = 1'b1;
        @(posedge CLK);
        #DRV_DLY;
      end
      present_row(idx);
      if (idx == CREDIT_ROW + `GSAU_QDEPTH) begin
        repeat (HOLD) begin
          @(negedge CLK);
          assert (!o_sb_ready)
          else report_error("ready stayed high with all credits in use");
        end
        wb_block = 1'b0;
      end
      wait_accept(idx >= CREDIT_ROW && idx < CREDIT_ROW + `GSAU_QDEPTH);
    end
    idle_inputs();
    drain_results();
    // a duplicated result would reach the writeback port within this window
    repeat (`GSAU_SA_LATENCY + 2) @(negedge CLK);
    if (!o_wb_valid) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      report_error("writeback still valid after every expected result was taken");
    end
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+.
gsau_pkg.sv
sa_if.sv
sync_fifo.sv
systolic_array.sv
gsau_control_unit.sv
gsau_top.sv
tb_gsau.sv
